/* hdl/csr_pkg.sv */
package csr_pkg;

   // machine-mode CSR addresses
   localparam logic [11:0] CSR_MSTATUS  = 12'h300;
   localparam logic [11:0] CSR_MIE      = 12'h304;
   localparam logic [11:0] CSR_MTVEC    = 12'h305;
   localparam logic [11:0] CSR_MSCRATCH = 12'h340;
   localparam logic [11:0] CSR_MEPC     = 12'h341;
   localparam logic [11:0] CSR_MCAUSE   = 12'h342;

   // funct3 of the SYSTEM opcode
   localparam logic [2:0] F3_PRIV = 3'b000;
   localparam logic [2:0] F3_RW   = 3'b001;
   localparam logic [2:0] F3_RS   = 3'b010;
   localparam logic [2:0] F3_RC   = 3'b011;
   localparam logic [2:0] F3_RWI  = 3'b101;
   localparam logic [2:0] F3_RSI  = 3'b110;
   localparam logic [2:0] F3_RCI  = 3'b111;

   // imm field that tells the PRIV operations apart
   localparam logic [11:0] IMM_ECALL  = 12'h000;
   localparam logic [11:0] IMM_EBREAK = 12'h001;
   localparam logic [11:0] IMM_MRET   = 12'h302;

   localparam logic [3:0] CAUSE_TIMER  = 4'd7;
   localparam logic [3:0] CAUSE_ECALL  = 4'd11;
   localparam logic [3:0] CAUSE_EBREAK = 4'd3;

   localparam logic [1:0] RSP_CSR  = 2'd0;
   localparam logic [1:0] RSP_TRAP = 2'd1;
   localparam logic [1:0] RSP_MRET = 2'd2;

   typedef union packed {
      logic [31:0] raw;
      struct packed {
         logic [11:0] csr;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } itype;
   } csr_insn_u;

endpackage

/* hdl/serial_pkg.sv */
package serial_pkg;

   // one bit per clock over the whole register
   localparam int XLEN  = 32;
   localparam int CNT_W = 5;

   // how the serial write bit is formed
   localparam logic [1:0] SRC_CSR = 2'b00;
   localparam logic [1:0] SRC_EXT = 2'b01;
   localparam logic [1:0] SRC_SET = 2'b10;
   localparam logic [1:0] SRC_CLR = 2'b11;

   // word store slots
   localparam logic [1:0] SLOT_MSCRATCH = 2'd0;
   localparam logic [1:0] SLOT_MEPC     = 2'd1;
   localparam logic [1:0] SLOT_MTVEC    = 2'd2;
   // never written so it always reads zero
   localparam logic [1:0] SLOT_SPARE    = 2'd3;

endpackage

/* hdl/csr_serial_ctrl.sv */
`timescale 1ns/1ps

module csr_serial_ctrl (
   input  logic                          i_clk,
   input  logic                          i_reset,
   input  logic                          i_req_valid,
   output logic                          o_req_ready,
   input  logic [serial_pkg::XLEN-1:0]   i_req_insn,
   input  logic [serial_pkg::XLEN-1:0]   i_req_rs1,
   input  logic [serial_pkg::XLEN-1:0]   i_req_pc,
   output logic                          o_rsp_valid,
   input  logic                          i_rsp_ready,
   output logic [1:0]                    o_rsp_kind,
   output logic [serial_pkg::XLEN-1:0]   o_rsp_data,
   input  logic                          i_irq_pending,
   input  logic                          i_csr_q,
   input  logic                          i_store_q,
   output logic                          o_en,
   output logic                          o_cnt0to3,
   output logic                          o_cnt2,
   output logic                          o_cnt3,
   output logic                          o_cnt7,
   output logic                          o_cnt_done,
   output logic                          o_mstatus_en,
   output logic                          o_mie_en,
   output logic                          o_mcause_en,
   output logic [1:0]                    o_csr_source,
   output logic                          o_d,
   output logic                          o_trap_taken,
   output logic                          o_trap_irq,
   output logic                          o_ebreak,
   output logic                          o_mret,
   output logic [1:0]                    o_store_rd_sel,
   output logic [1:0]                    o_store_wr_sel,
   output logic                          o_store_wr_en
);

   csr_pkg::csr_insn_u               insn;
   logic                             accept;
   logic                             is_priv;
   logic                             is_ecall;
   logic                             is_ebreak;
   logic                             is_mret;
   logic                             take_trap;
   logic [serial_pkg::XLEN-1:0]      operand;
   logic                             busy;
   logic                             rsp_valid;
   logic [serial_pkg::CNT_W-1:0]     cnt;
   logic [1:0]                       kind;
   logic                             mstatus_en;
   logic                             mie_en;
   logic                             mcause_en;
   logic [1:0]                       source;
   logic [1:0]                       rd_sel;
   logic [1:0]                       wr_sel;
   logic                             wr_en;
   logic [serial_pkg::XLEN-1:0]      d_sr;
   logic [serial_pkg::XLEN-1:0]      rsp_sr;
   logic                             res_bit;

   assign insn.raw    = i_req_insn;
   assign o_req_ready = !busy && !rsp_valid;
   assign accept      = i_req_valid && o_req_ready;

   assign is_priv   = insn.itype.funct3 == csr_pkg::F3_PRIV;
   assign is_ecall  = is_priv && insn.itype.csr == csr_pkg::IMM_ECALL;
   assign is_ebreak = is_priv && insn.itype.csr == csr_pkg::IMM_EBREAK;
   assign is_mret   = is_priv && insn.itype.csr == csr_pkg::IMM_MRET;
   // a pending interrupt replaces whatever was requested
   assign take_trap = i_irq_pending || is_ecall || is_ebreak;

   // single cycle strobes into csr_state on the accept cycle
   assign o_trap_taken = accept && take_trap;
   assign o_trap_irq   = i_irq_pending;
   assign o_ebreak     = is_ebreak;
   assign o_mret       = accept && is_mret && !i_irq_pending;

   // zero extended uimm for the immediate forms
   assign operand = insn.itype.funct3[2] ?
                    {{(serial_pkg::XLEN-5){1'b0}}, insn.itype.rs1} : i_req_rs1;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         busy       <= 1'b0;
         rsp_valid  <= 1'b0;
         cnt        <= '0;
         kind       <= csr_pkg::RSP_CSR;
         mstatus_en <= 1'b0;
         mie_en     <= 1'b0;
         mcause_en  <= 1'b0;
         source     <= serial_pkg::SRC_CSR;
         rd_sel     <= serial_pkg::SLOT_SPARE;
         wr_sel     <= serial_pkg::SLOT_SPARE;
         wr_en      <= 1'b0;
      end else begin
         if (accept) begin
            busy <= 1'b1;
         end else if (o_cnt_done) begin
            busy      <= 1'b0;
            rsp_valid <= 1'b1;
         end else if (rsp_valid && i_rsp_ready) begin
            rsp_valid <= 1'b0;
         end
         if (busy) begin
            cnt <= cnt + serial_pkg::CNT_W'(1);
         end
         if (accept) begin
            mstatus_en <= 1'b0;
            mie_en     <= 1'b0;
            mcause_en  <= 1'b0;
            if (take_trap) begin
               // pc goes to mepc while mtvec streams out
               kind   <= csr_pkg::RSP_TRAP;
               source <= serial_pkg::SRC_EXT;
               rd_sel <= serial_pkg::SLOT_MTVEC;
               wr_sel <= serial_pkg::SLOT_MEPC;
               wr_en  <= 1'b1;
            end else if (is_mret) begin
               kind   <= csr_pkg::RSP_MRET;
               source <= serial_pkg::SRC_CSR;
               rd_sel <= serial_pkg::SLOT_MEPC;
               wr_sel <= serial_pkg::SLOT_MEPC;
               wr_en  <= 1'b0;
            end else begin
               kind       <= csr_pkg::RSP_CSR;
               mstatus_en <= !is_priv && insn.itype.csr == csr_pkg::CSR_MSTATUS;
               mie_en     <= !is_priv && insn.itype.csr == csr_pkg::CSR_MIE;
               mcause_en  <= !is_priv && insn.itype.csr == csr_pkg::CSR_MCAUSE;
               case (insn.itype.funct3)
                  csr_pkg::F3_RW, csr_pkg::F3_RWI: source <= serial_pkg::SRC_EXT;
                  csr_pkg::F3_RS, csr_pkg::F3_RSI: source <= serial_pkg::SRC_SET;
                  csr_pkg::F3_RC, csr_pkg::F3_RCI: source <= serial_pkg::SRC_CLR;
                  default:                         source <= serial_pkg::SRC_CSR;
               endcase
               wr_en <= !is_priv;
               if (is_priv) begin
                  rd_sel <= serial_pkg::SLOT_SPARE;
                  wr_sel <= serial_pkg::SLOT_SPARE;
                  wr_en  <= 1'b0;
               end else if (insn.itype.csr == csr_pkg::CSR_MSCRATCH) begin
                  rd_sel <= serial_pkg::SLOT_MSCRATCH;
                  wr_sel <= serial_pkg::SLOT_MSCRATCH;
               end else if (insn.itype.csr == csr_pkg::CSR_MEPC) begin
                  rd_sel <= serial_pkg::SLOT_MEPC;
                  wr_sel <= serial_pkg::SLOT_MEPC;
               end else if (insn.itype.csr == csr_pkg::CSR_MTVEC) begin
                  rd_sel <= serial_pkg::SLOT_MTVEC;
                  wr_sel <= serial_pkg::SLOT_MTVEC;
               end else begin
                  rd_sel <= serial_pkg::SLOT_SPARE;
                  wr_sel <= serial_pkg::SLOT_SPARE;
                  wr_en  <= 1'b0;
               end
            end
         end
      end
   end

   // operand and result shift LSB first
   assign res_bit = (kind == csr_pkg::RSP_CSR) ? i_csr_q : i_store_q;

   always_ff @(posedge i_clk) begin
      if (accept) begin
         d_sr <= take_trap ? i_req_pc : operand;
      end else if (busy) begin
         d_sr   <= {1'b0, d_sr[serial_pkg::XLEN-1:1]};
         rsp_sr <= {res_bit, rsp_sr[serial_pkg::XLEN-1:1]};
      end
   end

   assign o_en       = busy;
   assign o_cnt0to3  = busy && cnt[serial_pkg::CNT_W-1:2] == '0;
   assign o_cnt2     = busy && cnt == serial_pkg::CNT_W'(2);
   assign o_cnt3     = busy && cnt == serial_pkg::CNT_W'(3);
   assign o_cnt7     = busy && cnt == serial_pkg::CNT_W'(7);
   assign o_cnt_done = busy && (&cnt);

   assign o_mstatus_en   = mstatus_en;
   assign o_mie_en       = mie_en;
   assign o_mcause_en    = mcause_en;
   assign o_csr_source   = source;
   assign o_d            = d_sr[0];
   assign o_store_rd_sel = rd_sel;
   assign o_store_wr_sel = wr_sel;
   assign o_store_wr_en  = wr_en;

   assign o_rsp_valid = rsp_valid;
   assign o_rsp_kind  = kind;
   assign o_rsp_data  = rsp_sr;

endmodule

/* hdl/csr_state.sv */
`timescale 1ns/1ps

module csr_state (
   input  logic        i_clk,
   input  logic        i_reset,
   input  logic        i_en,
   input  logic        i_cnt0to3,
   input  logic        i_cnt2,
   input  logic        i_cnt3,
   input  logic        i_cnt7,
   input  logic        i_cnt_done,
   input  logic        i_mstatus_en,
   input  logic        i_mie_en,
   input  logic        i_mcause_en,
   input  logic [1:0]  i_csr_source,
   input  logic        i_d,
   input  logic        i_trap_taken,
   input  logic        i_trap_irq,
   input  logic        i_ebreak,
   input  logic        i_mret,
   input  logic        i_mtip,
   input  logic        i_store_q,
   output logic        o_csr_in,
   output logic        o_q,
   output logic        o_irq_pending,
   output logic        o_new_irq
);

   logic        mstatus_mie;
   logic        mstatus_mpie;
   logic        mie_mtie;
   logic        mstatus_bit;
   logic        mcause31;
   logic [3:0]  mcause3_0;
   logic        mcause_bit;
   logic        csr_in;
   logic        csr_out;
   logic        timer_irq;
   logic        timer_irq_r;

   always_comb begin
      case (i_csr_source)
         serial_pkg::SRC_EXT: csr_in = i_d;
         serial_pkg::SRC_SET: csr_in = csr_out | i_d;
         serial_pkg::SRC_CLR: csr_in = csr_out & ~i_d;
         serial_pkg::SRC_CSR: csr_in = csr_out;
      endcase
   end

   // mcause only has bits 3:0 and 31
   assign mcause_bit = i_cnt0to3 ? mcause3_0[0] :
                       i_cnt_done ? mcause31 : 1'b0;

   assign csr_out = (i_mstatus_en & i_en & mstatus_bit) |
                    (i_mie_en & i_en & i_cnt7 & mie_mtie) |
                    i_store_q |
                    (i_mcause_en & i_en & mcause_bit);

   assign timer_irq = i_mtip & mstatus_mie & mie_mtie;

   assign o_csr_in      = csr_in;
   assign o_q           = csr_out;
   assign o_irq_pending = timer_irq;
   assign o_new_irq     = timer_irq & ~timer_irq_r;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         mstatus_mie  <= 1'b0;
         mstatus_mpie <= 1'b0;
         mie_mtie     <= 1'b0;
         mstatus_bit  <= 1'b0;
         mcause31     <= 1'b0;
         mcause3_0    <= '0;
         timer_irq_r  <= 1'b0;
      end else begin
         if (i_mstatus_en && i_cnt3) begin
            mstatus_mie <= csr_in;
         end
         if (i_mie_en && i_cnt7) begin
            mie_mtie <= csr_in;
         end
         // one cycle early so MIE lines up with bit 3
         mstatus_bit <= i_cnt2 & mstatus_mie;
         timer_irq_r <= timer_irq;

         if (i_mcause_en && i_en) begin
            if (i_cnt0to3) begin
               mcause3_0 <= {csr_in, mcause3_0[3:1]};
            end
            if (i_cnt_done) begin
               mcause31 <= csr_in;
            end
         end

         if (i_mret) begin
            mstatus_mie <= mstatus_mpie;
         end
         if (i_trap_taken) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mcause31     <= i_trap_irq;
            mcause3_0    <= i_trap_irq ? csr_pkg::CAUSE_TIMER :
                            i_ebreak   ? csr_pkg::CAUSE_EBREAK : csr_pkg::CAUSE_ECALL;
         end
      end
   end

endmodule

/* hdl/csr_word_store.sv */
`timescale 1ns/1ps

module csr_word_store (
   input  logic        i_clk,
   input  logic        i_reset,
   input  logic        i_shift,
   input  logic [1:0]  i_rd_sel,
   input  logic [1:0]  i_wr_sel,
   input  logic        i_wr_en,
   input  logic        i_wr_bit,
   output logic        o_rd_bit
);

   // current LSB of every slot
   logic [3:0] lsb;

   genvar g;
   generate
      for (g = 0; g < 4; g++) begin : g_slot
         logic [serial_pkg::XLEN-1:0] word_q;
         logic                        in_bit;

         // the addressed slot takes the new bit instead of its own
         assign in_bit = (i_wr_en && i_wr_sel == 2'(g)) ? i_wr_bit : word_q[0];

         // a full pass of 32 shifts leaves an untouched slot where it started
         always_ff @(posedge i_clk) begin
            if (i_reset) begin
               word_q <= '0;
            end else if (i_shift) begin
               word_q <= {in_bit, word_q[serial_pkg::XLEN-1:1]};
            end
         end

         assign lsb[g] = word_q[0];
      end
   endgenerate

   assign o_rd_bit = lsb[i_rd_sel];

endmodule

/* hdl/csr_unit_top.sv */
`timescale 1ns/1ps

module csr_unit_top (
   input  logic                          i_clk,
   input  logic                          i_reset,
   input  logic                          i_req_valid,
   output logic                          o_req_ready,
   input  logic [serial_pkg::XLEN-1:0]   i_req_insn,
   input  logic [serial_pkg::XLEN-1:0]   i_req_rs1,
   input  logic [serial_pkg::XLEN-1:0]   i_req_pc,
   output logic                          o_rsp_valid,
   input  logic                          i_rsp_ready,
   output logic [1:0]                    o_rsp_kind,
   output logic [serial_pkg::XLEN-1:0]   o_rsp_data,
   input  logic                          i_mtip,
   output logic                          o_new_irq
);

   logic        en;
   logic        cnt0to3;
   logic        cnt2;
   logic        cnt3;
   logic        cnt7;
   logic        cnt_done;
   logic        mstatus_en;
   logic        mie_en;
   logic        mcause_en;
   logic [1:0]  csr_source;
   logic        d;
   logic        trap_taken;
   logic        trap_irq;
   logic        ebreak;
   logic        mret;
   logic [1:0]  store_rd_sel;
   logic [1:0]  store_wr_sel;
   logic        store_wr_en;
   logic        irq_pending;
   logic        csr_q;
   logic        csr_in;
   logic        store_q;

   csr_serial_ctrl u_ctrl (
      .i_clk          (i_clk),
      .i_reset        (i_reset),
      .i_req_valid    (i_req_valid),
      .o_req_ready    (o_req_ready),
      .i_req_insn     (i_req_insn),
      .i_req_rs1      (i_req_rs1),
      .i_req_pc       (i_req_pc),
      .o_rsp_valid    (o_rsp_valid),
      .i_rsp_ready    (i_rsp_ready),
      .o_rsp_kind     (o_rsp_kind),
      .o_rsp_data     (o_rsp_data),
      .i_irq_pending  (irq_pending),
      .i_csr_q        (csr_q),
      .i_store_q      (store_q),
      .o_en           (en),
      .o_cnt0to3      (cnt0to3),
      .o_cnt2         (cnt2),
      .o_cnt3         (cnt3),
      .o_cnt7         (cnt7),
      .o_cnt_done     (cnt_done),
      .o_mstatus_en   (mstatus_en),
      .o_mie_en       (mie_en),
      .o_mcause_en    (mcause_en),
      .o_csr_source   (csr_source),
      .o_d            (d),
      .o_trap_taken   (trap_taken),
      .o_trap_irq     (trap_irq),
      .o_ebreak       (ebreak),
      .o_mret         (mret),
      .o_store_rd_sel (store_rd_sel),
      .o_store_wr_sel (store_wr_sel),
      .o_store_wr_en  (store_wr_en)
   );

   csr_state u_state (
      .i_clk          (i_clk),
      .i_reset        (i_reset),
      .i_en           (en),
      .i_cnt0to3      (cnt0to3),
      .i_cnt2         (cnt2),
      .i_cnt3         (cnt3),
      .i_cnt7         (cnt7),
      .i_cnt_done     (cnt_done),
      .i_mstatus_en   (mstatus_en),
      .i_mie_en       (mie_en),
      .i_mcause_en    (mcause_en),
      .i_csr_source   (csr_source),
      .i_d            (d),
      .i_trap_taken   (trap_taken),
      .i_trap_irq     (trap_irq),
      .i_ebreak       (ebreak),
      .i_mret         (mret),
      .i_mtip         (i_mtip),
      .i_store_q      (store_q),
      .o_csr_in       (csr_in),
      .o_q            (csr_q),
      .o_irq_pending  (irq_pending),
      .o_new_irq      (o_new_irq)
   );

   // merged write bit from csr_state feeds the store
   csr_word_store u_store (
      .i_clk          (i_clk),
      .i_reset        (i_reset),
      .i_shift        (en),
      .i_rd_sel       (store_rd_sel),
      .i_wr_sel       (store_wr_sel),
      .i_wr_en        (store_wr_en),
      .i_wr_bit       (csr_in),
      .o_rd_bit       (store_q)
   );

endmodule

/* bench/csr_unit_tb.sv */
`timescale 1ns/1ps

module csr_unit_tb;

   localparam int          CLK_PERIOD   = 20;
   localparam int          RESET_CYCLES = 8;
   localparam int          DRIVE_DELAY  = 2;
   localparam int          MAX_LINES    = 256;
   localparam int          RSP_LATENCY  = 33;
   localparam int unsigned SEED         = 32'h47c207f1;

   logic                        i_clk = 1'b0;
   logic                        i_reset;
   logic                        i_req_valid;
   logic                        o_req_ready;
   logic [serial_pkg::XLEN-1:0] i_req_insn;
   logic [serial_pkg::XLEN-1:0] i_req_rs1;
   logic [serial_pkg::XLEN-1:0] i_req_pc;
   logic                        o_rsp_valid;
   logic                        i_rsp_ready;
   logic [1:0]                  o_rsp_kind;
   logic [serial_pkg::XLEN-1:0] o_rsp_data;
   logic                        i_mtip;
   logic                        o_new_irq;

   // one entry per data file line
   logic                        vec_mtip  [MAX_LINES];
   logic [serial_pkg::XLEN-1:0] vec_insn  [MAX_LINES];
   logic [serial_pkg::XLEN-1:0] vec_rs1   [MAX_LINES];
   logic [serial_pkg::XLEN-1:0] vec_pc    [MAX_LINES];
   int                          vec_delay [MAX_LINES];
   logic [1:0]                  vec_kind  [MAX_LINES];
   logic [serial_pkg::XLEN-1:0] vec_data  [MAX_LINES];
   int                          vec_irqs  [MAX_LINES];

   int   n_lines   = 0;
   int   max_delay = 0;
   int   irq_count = 0;
   logic loaded    = 1'b0;

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   csr_unit_top u_dut (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_req_valid (i_req_valid),
      .o_req_ready (o_req_ready),
      .i_req_insn  (i_req_insn),
      .i_req_rs1   (i_req_rs1),
      .i_req_pc    (i_req_pc),
      .o_rsp_valid (o_rsp_valid),
      .i_rsp_ready (i_rsp_ready),
      .o_rsp_kind  (o_rsp_kind),
      .o_rsp_data  (o_rsp_data),
      .i_mtip      (i_mtip),
      .o_new_irq   (o_new_irq)
   );

   // o_new_irq is combinational so it is sampled half a cycle off the edge
   always @(negedge i_clk) begin
      if (!i_reset && o_new_irq) begin
         irq_count <= irq_count + 1;
      end
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_kind(input logic [1:0] got, input logic [1:0] exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("CHECK FAILED time %0d ns: %s kind %0d, expected %0d",
                            $time, what, got, exp));
      end
   endtask

   task automatic check_word(input logic [serial_pkg::XLEN-1:0] got,
                             input logic [serial_pkg::XLEN-1:0] exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("CHECK FAILED time %0d ns: %s 0x%08h, expected 0x%08h",
                            $time, what, got, exp));
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("CHECK FAILED time %0d ns: %s %b, expected %b",
                            $time, what, got, exp));
      end
   endtask

   // inputs change a little after the rising edge
   task automatic step();
      @(posedge i_clk);
      #DRIVE_DELAY;
   endtask

   task automatic run_vector(input int idx);
      csr_pkg::csr_insn_u insn;
      int                 idle;
      int                 latency;
      string              tag;
      insn.raw = vec_insn[idx];
      tag = $sformatf("line %0d (csr %03h funct3 %0d)", idx + 1, insn.itype.csr,
                      insn.itype.funct3);
      i_mtip = vec_mtip[idx];
      idle = int'($urandom % 4);
      repeat (idle) step();
      i_req_valid = 1'b1;
      i_req_insn  = insn.raw;
      i_req_rs1   = vec_rs1[idx];
      i_req_pc    = vec_pc[idx];
      while (o_req_ready !== 1'b1) step();
      step();
      i_req_valid = 1'b0;
      latency = 1;
      while (o_rsp_valid !== 1'b1) begin
         check_bit(o_req_ready, 1'b0, {tag, " req_ready while busy"});
         step();
         latency++;
      end
      check_word(32'(latency), 32'(RSP_LATENCY), {tag, " cycles to response"});
      check_kind(o_rsp_kind, vec_kind[idx], tag);
      check_word(o_rsp_data, vec_data[idx], {tag, " data"});
      // the response has to hold still while ready is low
      repeat (vec_delay[idx]) begin
         step();
         check_bit(o_rsp_valid, 1'b1, {tag, " rsp_valid under back-pressure"});
         check_bit(o_req_ready, 1'b0, {tag, " req_ready under back-pressure"});
         check_kind(o_rsp_kind, vec_kind[idx], {tag, " held"});
         check_word(o_rsp_data, vec_data[idx], {tag, " held data"});
      end
      i_rsp_ready = 1'b1;
      step();
      i_rsp_ready = 1'b0;
      check_bit(o_rsp_valid, 1'b0, {tag, " rsp_valid after handshake"});
      check_bit(o_req_ready, 1'b1, {tag, " req_ready after handshake"});
      check_word(32'(irq_count), 32'(vec_irqs[idx]), {tag, " new_irq pulses"});
   endtask

   initial begin : main
      int                          fd;
      int                          code;
      logic                        t_mtip;
      logic [serial_pkg::XLEN-1:0] t_insn;
      logic [serial_pkg::XLEN-1:0] t_rs1;
      logic [serial_pkg::XLEN-1:0] t_pc;
      int                          t_delay;
      logic [1:0]                  t_kind;
      logic [serial_pkg::XLEN-1:0] t_data;
      int                          t_irqs;
      i_reset     = 1'b1;
      i_req_valid = 1'b0;
      i_req_insn  = '0;
      i_req_rs1   = '0;
      i_req_pc    = '0;
      i_rsp_ready = 1'b0;
      i_mtip      = 1'b0;
      void'($urandom(SEED));

      fd = $fopen("bench/csr_unit_testdata.txt", "r");
      if (fd == 0) begin
         fail_run("cannot open bench/csr_unit_testdata.txt");
      end
      code = 8;
      while (code == 8 && n_lines < MAX_LINES) begin
         code = $fscanf(fd, "%h %h %h %h %d %h %h %d\n", t_mtip, t_insn, t_rs1, t_pc,
                        t_delay, t_kind, t_data, t_irqs);
         if (code == 8) begin
            vec_mtip[n_lines]  = t_mtip;
            vec_insn[n_lines]  = t_insn;
            vec_rs1[n_lines]   = t_rs1;
            vec_pc[n_lines]    = t_pc;
            vec_delay[n_lines] = t_delay;
            vec_kind[n_lines]  = t_kind;
            vec_data[n_lines]  = t_data;
            vec_irqs[n_lines]  = t_irqs;
            if (t_delay > max_delay) begin
               max_delay = t_delay;
            end
            n_lines++;
         end
      end
      $fclose(fd);
      if (code > 0 && code != 8) begin
         fail_run($sformatf("test data line %0d is malformed", n_lines + 1));
      end
      if (n_lines == 0) begin
         fail_run("test data file holds no vectors");
      end
      loaded = 1'b1;

      repeat (RESET_CYCLES) step();
      i_reset = 1'b0;
      check_bit(o_req_ready, 1'b1, "req_ready after reset");
      check_bit(o_rsp_valid, 1'b0, "rsp_valid after reset");
      check_bit(o_new_irq, 1'b0, "new_irq after reset");

      for (int idx = 0; idx < n_lines; idx++) begin
         run_vector(idx);
      end

      step();
      if (o_req_ready === 1'b1 && o_rsp_valid === 1'b0) begin
         $display("sim passed");
         $finish;
      end else begin
         fail_run("DUT did not return to idle after the last vector");
      end
   end

   initial begin : watchdog
      int limit;
      wait (loaded);
      limit = RESET_CYCLES + n_lines * (40 + max_delay);
      repeat (limit) @(posedge i_clk);
      fail_run($sformatf("timeout: vectors did not finish within %0d clock cycles", limit));
   end

endmodule

/* bench/csr_unit_testdata.txt */
0 340110F3 DEADBEEF 00001000 0 0 00000000 0
0 340110F3 12345678 00001004 2 0 DEADBEEF 0
0 340AD0F3 FFFFFFFF 00001008 1 0 12345678 0
0 340120F3 F0000000 0000100C 0 0 00000015 0
0 340130F3 00000005 00001010 3 0 F0000015 0
0 340120F3 00000000 00001014 0 0 F0000010 0
0 305110F3 80000100 00001018 5 0 00000000 0
0 341110F3 00002468 0000101C 0 0 00000000 0
0 341FD0F3 FFFFFFFF 00001020 1 0 00002468 0
0 305120F3 00000000 00001024 0 0 80000100 0
0 300120F3 FFFFFFFF 00001028 2 0 00000000 0
0 300120F3 00000000 0000102C 0 0 00000008 0
0 300130F3 FFFFFFF7 00001030 4 0 00000008 0
0 300470F3 FFFFFFFF 00001034 0 0 00000008 0
0 300460F3 00000000 00001038 1 0 00000000 0
0 304120F3 FFFFFFFF 0000103C 0 0 00000000 0
0 304130F3 00000080 00001040 3 0 00000080 0
0 304120F3 00000080 00001044 0 0 00000000 0
0 304120F3 00000000 00001048 2 0 00000080 0
0 7C0110F3 FFFFFFFF 0000104C 0 0 00000000 0
0 7C0120F3 00000000 00001050 1 0 00000000 0
0 342120F3 00000000 00001054 0 0 00000000 0
0 00000073 00000000 00000400 2 1 80000100 0
0 341120F3 00000000 00001058 0 0 00000400 0
0 342120F3 00000000 0000105C 1 0 0000000B 0
0 300120F3 00000000 00001060 0 0 00000000 0
0 30200073 00000000 00001064 3 2 00000400 0
0 300120F3 00000000 00001068 0 0 00000008 0
0 300470F3 00000000 0000106C 1 0 00000008 0
0 00100073 00000000 00000888 0 1 80000100 0
0 342120F3 00000000 00001070 2 0 00000003 0
0 341120F3 00000000 00001074 0 0 00000888 0
0 30200073 00000000 00001078 4 2 00000888 0
0 300120F3 00000000 0000107C 0 0 00000000 0
0 300460F3 00000000 00001080 1 0 00000000 0
1 340120F3 00000000 00000C00 0 1 80000100 1
1 342120F3 00000000 00001084 2 0 80000007 1
1 341120F3 00000000 00001088 0 0 00000C00 1
1 30200073 00000000 0000108C 5 2 00000C00 2
1 340110F3 55555555 00000D00 0 1 80000100 2
0 340120F3 00000000 00001090 1 0 F0000010 2
0 304130F3 00000080 00001094 0 0 00000080 2
1 30200073 00000000 00001098 2 2 00000D00 2
1 300120F3 00000000 0000109C 0 0 00000008 2
0 341120F3 00000000 000010A0 3 0 00000D00 2
0 305120F3 00000000 000010A4 0 0 80000100 2

/* csr_unit_top.f */
hdl/csr_pkg.sv
hdl/serial_pkg.sv
hdl/csr_serial_ctrl.sv
hdl/csr_state.sv
hdl/csr_word_store.sv
hdl/csr_unit_top.sv
bench/csr_unit_tb.sv

/* Makefile */
# Verilator build and run for the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
LOG       ?= sim.log
FILELIST  ?= csr_unit_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timescale 1ns/1ps

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP LOG FILELIST OBJ_DIR VFLAGS"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
